// File: design/bsram_request_stage.sv
/*
 * save RAM request register, one cycle behind the SNES bus
 * reads qualified by F phase, writes by R phase
 * SA type mappers read without the RD strobe
 */
module bsram_request_stage import snes_mem_pkg::*; #(
    parameter int bsram_aw = BSRAM_AW_DEFAULT
) (
    input  logic                wclk,
    input  logic                resetn,
    input  logic                f_phase,
    input  logic                r_phase,
    input  logic                bsram_ce_n,
    input  logic                bsram_rd_n,
    input  logic                bsram_we_n,
    input  logic [bsram_aw-1:0] bsram_addr,
    input  byte_t               bsram_d,
    input  map_ctrl_t           map_ctrl,
    output logic                bs_rd,
    output logic                bs_wr,
    output logic [bsram_aw-1:0] bs_addr,
    output byte_t               bs_din
);

    logic sa_map;   // mapper reads save RAM without RD

    assign sa_map = (map_ctrl[7:4] == MAP_SA_TYPE);

    // address and data follow the bus every cycle
    always_ff @(posedge wclk) begin
        bs_addr <= bsram_addr;
        bs_din  <= bsram_d;
    end

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            bs_rd <= 1'b0;
            bs_wr <= 1'b0;
        end else begin
            bs_rd <= ~bsram_ce_n & (~bsram_rd_n | sa_map) & f_phase;
            bs_wr <= ~bsram_ce_n & ~bsram_we_n & r_phase;
        end
    end

endmodule

// File: design/load_sequencer.sv
/*
 * ROM image loader address counter and run enable
 * load_valid must stay low in the cycle after loading rises
 * run_enable is registered, one cycle behind busy, pause and loaded
 */
module load_sequencer import snes_mem_pkg::*; (
    input  logic      wclk,
    input  logic      resetn,
    input  logic      loading,      // loader active level
    input  logic      load_valid,   // one byte per strobe
    input  byte_t     load_data,
    input  logic      mem_busy,     // memory still initializing
    input  logic      frame_pause,  // frame sync hold request
    output logic      load_wr,
    output mem_addr_t load_addr,
    output byte_t     load_byte,
    output logic      run_enable
);

    logic loading_r;        // previous loading level
    logic loaded;           // image fully written
    logic load_start;
    logic load_done;

    assign load_start = loading & ~loading_r;   // rising edge
    assign load_done  = ~loading & loading_r;   // falling edge

    // write strobe and data go straight to the arbiter
    assign load_wr   = loading & load_valid;
    assign load_byte = load_data;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading_r <= 1'b0;
            loaded    <= 1'b0;
            load_addr <= '0;
        end else begin
            loading_r <= loading;
            if (load_start) begin
                load_addr <= '0;        // new image starts at 0
                loaded    <= 1'b0;
            end else if (load_valid) begin
                load_addr <= load_addr + 24'd1;
            end
            if (load_done)
                loaded <= 1'b1;         // seen one cycle after loading drops
        end
    end

    // SNES only runs once loaded and memory is free
    always_ff @(posedge wclk) begin
        if (!resetn)
            run_enable <= 1'b0;
        else
            run_enable <= loaded & ~mem_busy & ~frame_pause;
    end

endmodule

// File: design/mem_request_arbiter.sv
/*
 * one registered memory request per cycle, fixed priority
 * loader writes win, then ROM reads on F phase, then WRAM
 * all request fields read zero when nothing is issued
 */
module mem_request_arbiter import snes_mem_pkg::*; #(
    parameter logic [6:0] wram_bank = WRAM_BANK_DEFAULT
) (
    input  logic       wclk,
    input  logic       resetn,
    input  logic       run_enable,
    input  logic       sysclkf_ce,   // SNES CPU F phase strobe
    input  logic       sysclkr_ce,   // SNES CPU R phase strobe
    input  logic       load_wr,
    input  mem_addr_t  load_addr,
    input  byte_t      load_byte,
    input  logic       rom_ce_n,
    input  mem_addr_t  rom_addr,
    input  logic       wram_ce_n,
    input  logic       wram_rd_n,
    input  logic       wram_we_n,
    input  wram_addr_t wram_addr,
    input  byte_t      wram_d,
    output logic       f_phase,
    output logic       r_phase,
    output logic       mem_rd,
    output logic       mem_wr,
    output mem_addr_t  mem_addr,
    output word_t      mem_din,
    output lane_sel_t  mem_ds,
    output logic       mem_port      // 1 selects the WRAM read port
);

    logic      wram_rd;
    logic      wram_wr;
    logic      nxt_rd;
    logic      nxt_wr;
    mem_addr_t nxt_addr;
    word_t     nxt_din;
    lane_sel_t nxt_ds;
    logic      nxt_port;

    assign wram_rd = ~wram_ce_n & ~wram_rd_n & f_phase;             // reads on F
    assign wram_wr = ~wram_ce_n & ~wram_we_n & r_phase & ~wram_rd;  // writes on R, read wins

    // phase strobes only count while the SNES runs
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            f_phase <= 1'b0;
            r_phase <= 1'b0;
        end else begin
            f_phase <= sysclkf_ce & run_enable;
            r_phase <= sysclkr_ce & run_enable;
        end
    end

    // request select
    always_comb begin
        nxt_rd   = 1'b0;
        nxt_wr   = 1'b0;
        nxt_addr = '0;
        nxt_din  = '0;
        nxt_ds   = '0;
        nxt_port = 1'b0;
        if (load_wr) begin
            nxt_wr   = 1'b1;
            nxt_addr = load_addr;
            nxt_din  = {load_byte, load_byte};          // byte on both halves
            nxt_ds   = {load_addr[0], ~load_addr[0]};   // odd address is upper lane
        end else if (~rom_ce_n && f_phase) begin
            nxt_rd   = 1'b1;
            nxt_addr = rom_addr;
            nxt_ds   = 2'b11;                            // full word, steered later
        end else if (wram_rd || wram_wr) begin
            nxt_addr = {wram_bank, wram_addr};
            nxt_din  = {wram_d, wram_d};
            nxt_ds   = {wram_addr[0], ~wram_addr[0]};
            nxt_port = 1'b1;
            nxt_rd   = wram_rd;
            nxt_wr   = wram_wr;     // data valid by R phase
        end
    end

    // request register, lasts one cycle
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            mem_rd   <= 1'b0;
            mem_wr   <= 1'b0;
            mem_addr <= '0;
            mem_din  <= '0;
            mem_ds   <= '0;
            mem_port <= 1'b0;
        end else begin
            mem_rd   <= nxt_rd;
            mem_wr   <= nxt_wr;
            mem_addr <= nxt_addr;
            mem_din  <= nxt_din;
            mem_ds   <= nxt_ds;
            mem_port <= nxt_port;
        end
    end

endmodule

// File: design/read_data_steer.sv
/*
 * byte steering of memory read data back to the SNES
 * ROM and WRAM paths are combinational from the memory ports
 * ARAM lane is latched on each ARAM read and held until the next
 */
module read_data_steer import snes_mem_pkg::*; (
    input  logic  wclk,
    input  logic  resetn,
    input  logic  rom_addr0,     // ROM byte address bit 0
    input  logic  rom_word,      // 16-bit ROM fetch
    input  logic  wram_addr0,
    input  logic  aram_ce_n,
    input  logic  aram_oe_n,
    input  logic  aram_addr0,
    input  word_t mem_port0,     // ROM read port
    input  word_t mem_port1,     // WRAM read port
    input  word_t aram_dout,
    output word_t rom_q,
    output byte_t wram_q,
    output byte_t aram_q
);

    logic aram_rd;
    logic aram_lane;    // 1 takes the upper byte

    assign aram_rd = ~aram_ce_n & ~aram_oe_n;

    // odd byte reads want the upper byte in the low half
    always_comb begin
        if (rom_word || !rom_addr0)
            rom_q = mem_port0;
        else
            rom_q = {mem_port0[7:0], mem_port0[15:8]};
    end

    assign wram_q = wram_addr0 ? mem_port1[15:8] : mem_port1[7:0];

    // data returns after the read strobe drops, so remember the lane
    always_ff @(posedge wclk) begin
        if (!resetn)
            aram_lane <= 1'b0;
        else if (aram_rd)
            aram_lane <= aram_addr0;
    end

    assign aram_q = aram_lane ? aram_dout[15:8] : aram_dout[7:0];

endmodule

// File: design/snes_mem_bridge.sv
/*
 * SNES side memory request path, loader through to read data
 * memory controller and SNES core sit outside, all on wclk
 * mem_busy only holds run_enable, loader writes still pass
 */
module snes_mem_bridge import snes_mem_pkg::*; #(
    parameter logic [6:0] wram_bank = WRAM_BANK_DEFAULT,  // WRAM bank base
    parameter int         bsram_aw  = BSRAM_AW_DEFAULT    // save RAM address width
) (
    input  logic                wclk,
    input  logic                resetn,
    // loader
    input  logic                loading,
    input  logic                load_valid,
    input  byte_t               load_data,
    // memory status
    input  logic                mem_busy,
    input  logic                frame_pause,
    // SNES CPU phase strobes
    input  logic                sysclkf_ce,
    input  logic                sysclkr_ce,
    // ROM bus
    input  logic                rom_ce_n,
    input  mem_addr_t           rom_addr,
    input  logic                rom_word,
    // WRAM bus
    input  logic                wram_ce_n,
    input  logic                wram_rd_n,
    input  logic                wram_we_n,
    input  wram_addr_t          wram_addr,
    input  byte_t               wram_d,
    // save RAM bus
    input  logic                bsram_ce_n,
    input  logic                bsram_rd_n,
    input  logic                bsram_we_n,
    input  logic [bsram_aw-1:0] bsram_addr,
    input  byte_t               bsram_d,
    input  map_ctrl_t           map_ctrl,
    // ARAM bus, only bit 0 of the address matters here
    input  logic                aram_ce_n,
    input  logic                aram_oe_n,
    input  aram_addr_t          aram_addr,
    // memory read data
    input  word_t               mem_port0,
    input  word_t               mem_port1,
    input  word_t               aram_dout,
    output logic                run_enable,
    // memory request
    output logic                mem_rd,
    output logic                mem_wr,
    output mem_addr_t           mem_addr,
    output word_t               mem_din,
    output lane_sel_t           mem_ds,
    output logic                mem_port,
    // save RAM request
    output logic                bs_rd,
    output logic                bs_wr,
    output logic [bsram_aw-1:0] bs_addr,
    output byte_t               bs_din,
    // read data to the SNES
    output word_t               rom_q,
    output byte_t               wram_q,
    output byte_t               aram_q
);

    logic      load_wr;     // loader byte this cycle
    mem_addr_t load_addr;
    byte_t     load_byte;
    logic      f_phase;     // registered, enable qualified
    logic      r_phase;

    load_sequencer load_seq_i (
        .wclk(wclk), .resetn(resetn),
        .loading(loading), .load_valid(load_valid), .load_data(load_data),
        .mem_busy(mem_busy), .frame_pause(frame_pause),
        .load_wr(load_wr), .load_addr(load_addr), .load_byte(load_byte),
        .run_enable(run_enable)
    );

    mem_request_arbiter #(.wram_bank(wram_bank)) arb_i (
        .wclk(wclk), .resetn(resetn), .run_enable(run_enable),
        .sysclkf_ce(sysclkf_ce), .sysclkr_ce(sysclkr_ce),
        .load_wr(load_wr), .load_addr(load_addr), .load_byte(load_byte),
        .rom_ce_n(rom_ce_n), .rom_addr(rom_addr),
        .wram_ce_n(wram_ce_n), .wram_rd_n(wram_rd_n), .wram_we_n(wram_we_n),
        .wram_addr(wram_addr), .wram_d(wram_d),
        .f_phase(f_phase), .r_phase(r_phase),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_din(mem_din), .mem_ds(mem_ds), .mem_port(mem_port)
    );

    bsram_request_stage #(.bsram_aw(bsram_aw)) bsram_i (
        .wclk(wclk), .resetn(resetn), .f_phase(f_phase), .r_phase(r_phase),
        .bsram_ce_n(bsram_ce_n), .bsram_rd_n(bsram_rd_n), .bsram_we_n(bsram_we_n),
        .bsram_addr(bsram_addr), .bsram_d(bsram_d), .map_ctrl(map_ctrl),
        .bs_rd(bs_rd), .bs_wr(bs_wr), .bs_addr(bs_addr), .bs_din(bs_din)
    );

    read_data_steer steer_i (
        .wclk(wclk), .resetn(resetn),
        .rom_addr0(rom_addr[0]), .rom_word(rom_word),   // byte address lsb only
        .wram_addr0(wram_addr[0]),
        .aram_ce_n(aram_ce_n), .aram_oe_n(aram_oe_n), .aram_addr0(aram_addr[0]),
        .mem_port0(mem_port0), .mem_port1(mem_port1), .aram_dout(aram_dout),
        .rom_q(rom_q), .wram_q(wram_q), .aram_q(aram_q)
    );

endmodule

// File: design/snes_mem_pkg.sv
/*
 * shared widths and constants for the SNES memory request bridge
 * addresses are byte addresses into a 16 MB space, memory words are 16 bits
 * WRAM placement and save-RAM width are only defaults, the top level can override
 */
package snes_mem_pkg;

    // basic data widths
    typedef logic [7:0]  byte_t;      // one data byte
    typedef logic [15:0] word_t;      // one memory word

    // address spaces
    typedef logic [23:0] mem_addr_t;  // 16 MB byte address
    typedef logic [16:0] wram_addr_t; // 128 KB of WRAM
    typedef logic [15:0] aram_addr_t; // 64 KB of audio RAM

    // byte lane enables, bit 1 is the upper byte
    typedef logic [1:0]  lane_sel_t;

    // cartridge mapper control byte, upper nibble is the mapper type
    typedef logic [7:0]  map_ctrl_t;

    // this mapper type reads save RAM without asserting RD
    localparam logic [3:0] MAP_SA_TYPE = 4'hC;

    // upper 7 address bits of WRAM, puts it at banks EE-EF
    localparam logic [6:0] WRAM_BANK_DEFAULT = 7'b1110_111;

    // save RAM address width, 1 MB
    localparam int BSRAM_AW_DEFAULT = 20;

endpackage

// File: sim/snes_mem_bridge_assert.sv
/*
 * request and phase checks bound into every mem_request_arbiter
 * an idle request carries all-zero fields, WRAM port included
 */
module snes_mem_assert import snes_mem_pkg::*; (
    input logic      wclk,
    input logic      resetn,
    input logic      run_enable,
    input logic      f_phase,
    input logic      r_phase,
    input logic      mem_rd,
    input logic      mem_wr,
    input mem_addr_t mem_addr,
    input word_t     mem_din,
    input lane_sel_t mem_ds,
    input logic      mem_port
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;   // failed assertions so far

    // one direction per request
    rd_wr_excl: assert property (@(posedge wclk) disable iff (!resetn)
        !(mem_rd && mem_wr))
        else begin
            assert_fails++;
            $error("mem_rd and mem_wr high together");
        end

    idle_zero: assert property (@(posedge wclk) disable iff (!resetn)
        (!mem_rd && !mem_wr) |->
            (mem_addr == '0 && mem_din == '0 && mem_ds == '0 && !mem_port))
        else begin
            assert_fails++;
            $error("idle request carries nonzero fields");
        end

    // phases only follow a running SNES
    f_needs_run: assert property (@(posedge wclk) disable iff (!resetn)
        f_phase |-> $past(run_enable))
        else begin
            assert_fails++;
            $error("f_phase high without run_enable");
        end

    r_needs_run: assert property (@(posedge wclk) disable iff (!resetn)
        r_phase |-> $past(run_enable))
        else begin
            assert_fails++;
            $error("r_phase high without run_enable");
        end

endmodule

bind mem_request_arbiter snes_mem_assert assert_i (
    .wclk(wclk), .resetn(resetn), .run_enable(run_enable),
    .f_phase(f_phase), .r_phase(r_phase),
    .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr),
    .mem_din(mem_din), .mem_ds(mem_ds), .mem_port(mem_port)
);

// File: sim/snes_mem_bridge_tb.sv
/*
 * random traffic through the bridge against a cycle model kept in this testbench
 * inputs change on the falling edge, outputs are compared on the next falling edge
 * expects the default WRAM bank and a 20 bit save RAM address
 */
module snes_mem_bridge_tb import snes_mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYC  = 5;
    localparam int IDLE_CYC   = 40;
    localparam int LOAD_BYTES = 64;
    localparam int BURST_MAX  = LOAD_BYTES * 4 + 2;  // gaps of up to 3 cycles
    localparam int RUN_CYC    = 2000;
    localparam int LIMIT      = RESET_CYC + IDLE_CYC + 2 * BURST_MAX + 2 * RUN_CYC + 100;

    logic wclk, resetn;
    logic loading, load_valid, mem_busy, frame_pause, sysclkf_ce, sysclkr_ce;
    byte_t load_data, wram_d, bsram_d;
    logic rom_ce_n, rom_word, wram_ce_n, wram_rd_n, wram_we_n;
    logic bsram_ce_n, bsram_rd_n, bsram_we_n, aram_ce_n, aram_oe_n;
    mem_addr_t rom_addr;
    wram_addr_t wram_addr;
    logic [BSRAM_AW_DEFAULT-1:0] bsram_addr;
    map_ctrl_t map_ctrl;
    aram_addr_t aram_addr;
    word_t mem_port0, mem_port1, aram_dout;
    logic run_enable, mem_rd, mem_wr, mem_port, bs_rd, bs_wr;
    mem_addr_t mem_addr;
    word_t mem_din, rom_q;
    lane_sel_t mem_ds;
    logic [BSRAM_AW_DEFAULT-1:0] bs_addr;
    byte_t bs_din, wram_q, aram_q;

    // model state
    logic m_loading_r, m_loaded, m_run, m_f, m_r, m_rd, m_wr, m_port;
    logic m_bs_rd, m_bs_wr, m_lane;
    mem_addr_t m_load_addr, m_addr;
    word_t m_din;
    lane_sel_t m_ds;
    logic [BSRAM_AW_DEFAULT-1:0] m_bs_addr;
    byte_t m_bs_din;

    logic [31:0] lfsr;
    int errors, checks, rom_reads;
    int cycles = 0;

    snes_mem_bridge dut_i (.*);

    initial begin
        wclk = 1'b0;
        forever #2 wclk = ~wclk;   // 4 ns period
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};     // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        take_bits = r;
    endfunction

    task automatic drive_random(input logic ld, input logic lv);
        map_ctrl_t mc;
        loading     = ld;
        load_valid  = lv;
        load_data   = byte_t'(take_bits(8));
        mem_busy    = (take_bits(3) == 0);     // rare holds
        frame_pause = (take_bits(3) == 0);
        sysclkf_ce  = take_bits(1) != 0;
        sysclkr_ce  = take_bits(1) != 0;
        rom_ce_n    = take_bits(1) != 0;
        rom_addr    = mem_addr_t'(take_bits(24));
        rom_word    = take_bits(1) != 0;
        wram_ce_n   = take_bits(1) != 0;
        wram_rd_n   = take_bits(1) != 0;
        wram_we_n   = take_bits(1) != 0;
        wram_addr   = wram_addr_t'(take_bits(17));
        wram_d      = byte_t'(take_bits(8));
        bsram_ce_n  = take_bits(1) != 0;
        bsram_rd_n  = take_bits(1) != 0;
        bsram_we_n  = take_bits(1) != 0;
        bsram_addr  = BSRAM_AW_DEFAULT'(take_bits(BSRAM_AW_DEFAULT));
        bsram_d     = byte_t'(take_bits(8));
        mc = map_ctrl_t'(take_bits(8));
        if (take_bits(1) != 0)
            mc[7:4] = MAP_SA_TYPE;              // half the time an SA mapper
        map_ctrl    = mc;
        aram_ce_n   = take_bits(1) != 0;
        aram_oe_n   = take_bits(1) != 0;
        aram_addr   = aram_addr_t'(take_bits(16));
        mem_port0   = word_t'(take_bits(16));
        mem_port1   = word_t'(take_bits(16));
        aram_dout   = word_t'(take_bits(16));
    endtask

    // one rising edge of the model, old state on the right hand side
    task automatic model_edge();
        logic w_rd;
        logic w_wr;
        w_rd = !wram_ce_n && !wram_rd_n;
        w_wr = !wram_ce_n && !wram_we_n;
        m_rd = 1'b0;
        m_wr = 1'b0;
        m_addr = '0;
        m_din = '0;
        m_ds = '0;
        m_port = 1'b0;
        if (loading && load_valid) begin
            m_wr = 1'b1;
            m_addr = m_load_addr;
            m_din = {load_data, load_data};
            m_ds = m_load_addr[0] ? 2'b10 : 2'b01;
        end else if (!rom_ce_n && m_f) begin
            m_rd = 1'b1;
            m_addr = rom_addr;
            m_ds = 2'b11;
            rom_reads++;
        end else if ((w_rd && m_f) || (w_wr && m_r)) begin
            m_addr = {WRAM_BANK_DEFAULT, wram_addr};
            m_din = {wram_d, wram_d};
            m_ds = wram_addr[0] ? 2'b10 : 2'b01;
            m_port = 1'b1;
            if (w_rd && m_f)
                m_rd = 1'b1;            // read goes first on a clash
            else
                m_wr = 1'b1;
        end
        m_bs_rd = !bsram_ce_n && (!bsram_rd_n || map_ctrl[7:4] == 4'hC) && m_f;
        m_bs_wr = !bsram_ce_n && !bsram_we_n && m_r;
        m_bs_addr = bsram_addr;         // no reset on these
        m_bs_din = bsram_d;
        m_f = sysclkf_ce && m_run;
        m_r = sysclkr_ce && m_run;
        m_run = m_loaded && !mem_busy && !frame_pause;
        if (loading && !m_loading_r) begin
            m_load_addr = '0;
            m_loaded = 1'b0;
        end else if (load_valid) begin
            m_load_addr = m_load_addr + 1;
        end
        if (!loading && m_loading_r)
            m_loaded = 1'b1;
        m_loading_r = loading;
        if (!aram_ce_n && !aram_oe_n)
            m_lane = aram_addr[0];
        if (!resetn) begin
            {m_loading_r, m_loaded, m_run, m_f, m_r, m_lane} = '0;
            {m_rd, m_wr, m_port, m_bs_rd, m_bs_wr} = '0;
            m_load_addr = '0;
            m_addr = '0;
            m_din = '0;
            m_ds = '0;
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_outputs();
        word_t exp_rom;
        byte_t exp_wram;
        byte_t exp_aram;
        exp_rom = mem_port0;
        if (!rom_word && rom_addr[0]) begin
            exp_rom[7:0]  = mem_port0[15:8];    // odd byte read, upper byte comes down
            exp_rom[15:8] = mem_port0[7:0];
        end
        exp_wram = byte_t'(mem_port1 >> (wram_addr[0] ? 8 : 0));
        exp_aram = byte_t'(aram_dout >> (m_lane ? 8 : 0));
        check_field("run_enable", run_enable, m_run);
        check_field("load_addr", dut_i.load_addr, m_load_addr);
        check_field("loaded", dut_i.load_seq_i.loaded, m_loaded);
        check_field("f_phase", dut_i.f_phase, m_f);
        check_field("r_phase", dut_i.r_phase, m_r);
        check_field("mem_rd", mem_rd, m_rd);
        check_field("mem_wr", mem_wr, m_wr);
        check_field("mem_addr", mem_addr, m_addr);
        check_field("mem_din", mem_din, m_din);
        check_field("mem_ds", mem_ds, m_ds);
        check_field("mem_port", mem_port, m_port);
        check_field("bs_rd", bs_rd, m_bs_rd);
        check_field("bs_wr", bs_wr, m_bs_wr);
        check_field("bs_addr", bs_addr, m_bs_addr);
        check_field("bs_din", bs_din, m_bs_din);
        check_field("rom_q", rom_q, exp_rom);
        check_field("wram_q", wram_q, exp_wram);
        check_field("aram_q", aram_q, exp_aram);
    endtask

    task automatic step();
        @(posedge wclk);
        model_edge();
        @(negedge wclk);
        check_outputs();
    endtask

    task automatic load_burst(input int nbytes);
        int gap;
        drive_random(1'b1, 1'b0);       // rise cycle, no byte here
        step();
        for (int i = 0; i < nbytes; i++) begin
            gap = take_bits(2);
            repeat (gap) begin
                drive_random(1'b1, 1'b0);
                step();
            end
            drive_random(1'b1, 1'b1);
            step();
        end
        drive_random(1'b0, 1'b0);       // loading drops
        step();
    endtask

    always @(posedge wclk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout, run still going after %0d cycles", LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        lfsr = 32'h53c9;
        errors = 0;
        checks = 0;
        rom_reads = 0;
        resetn = 1'b0;
        repeat (RESET_CYC) begin
            drive_random(1'b0, 1'b0);
            step();
        end
        resetn = 1'b1;
        repeat (IDLE_CYC) begin         // nothing loaded yet, enable must stay low
            drive_random(1'b0, 1'b0);
            step();
        end
        load_burst(LOAD_BYTES);
        repeat (RUN_CYC) begin
            drive_random(1'b0, 1'b0);
            step();
        end
        load_burst(LOAD_BYTES);         // reload while the SNES runs, loader wins
        repeat (RUN_CYC) begin
            drive_random(1'b0, 1'b0);
            step();
        end
        if (rom_reads == 0) begin
            errors++;
            $display("no ROM read was ever issued, traffic never reached the arbiter");
        end
        errors = errors + dut_i.arb_i.assert_i.assert_fails;
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: snes_mem_bridge.f
design/snes_mem_pkg.sv
design/load_sequencer.sv
design/mem_request_arbiter.sv
design/bsram_request_stage.sv
design/read_data_steer.sv
design/snes_mem_bridge.sv
sim/snes_mem_bridge_assert.sv
sim/snes_mem_bridge_tb.sv
